// ==== source/link_pkg.sv ====
// link kernel shared definitions
// channel geometry, calibration timing, test patterns and line types
// used by the sequencer, the channels and the top level

`default_nettype none

package link_pkg;

  // ------------------------------------------------------------
  // channel geometry
  // ------------------------------------------------------------
  localparam int LINK_CHANNELS = 2;
  localparam int CHANNEL_WIDTH = 8;

  // inbound fifo depth, also the starting credit count
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;
  // one extra bit so the counter can hold a full fifo worth
  localparam int CREDIT_W      = LG_FIFO_DEPTH + 1;

  // dequeues per token toggle, and credits returned per toggle
  localparam int LG_TOKEN_DECIMATION = 1;
  localparam int TOKEN_CREDITS       = 1 << LG_TOKEN_DECIMATION;

  // ------------------------------------------------------------
  // calibration timing
  // ------------------------------------------------------------
  localparam int WAIT_AFTER_RESET = 16;
  localparam int PREPARE_CYCLES   = 16;
  localparam int TEST_COUNT       = 3;
  localparam int TEST_HOLD_CYCLES = 4;
  localparam int TEST_TIMEOUT     = 32;

  // counter widths derived from the timing above
  localparam int TEST_IDX_W = $clog2(TEST_COUNT);
  localparam int HOLD_CNT_W = $clog2(TEST_HOLD_CYCLES + 1);
  localparam int CAL_CNT_W  = $clog2(TEST_TIMEOUT + 1);

  // pattern k is sent on every channel during test k
  localparam logic [TEST_COUNT-1:0][CHANNEL_WIDTH-1:0] TEST_PATTERN = {
    8'h3C,
    8'hAA,
    8'h55
  };

  // ------------------------------------------------------------
  // types
  // ------------------------------------------------------------
  // one word on a transmission line
  typedef struct packed {
    logic                     valid;
    logic [CHANNEL_WIDTH-1:0] data;
  } link_word_t;

  // all channels side by side
  typedef link_word_t [LINK_CHANNELS-1:0] link_tline_t;

  // test request broadcast to the inbound channels
  typedef struct packed {
    logic                  req;
    logic [TEST_IDX_W-1:0] index;
  } calib_test_t;

  // calibration sequencer states
  typedef enum logic [2:0] {
    CAL_WAIT,
    CAL_PREPARE,
    CAL_TEST_REQ,
    CAL_TEST_RELEASE,
    CAL_DONE
  } calib_state_e;

endpackage

`default_nettype wire

// ==== source/link_calib_ctrl.sv ====
// link calibration sequencer
// waits after reset, holds the remote reset through prepare, then runs
// the test rounds with a four-phase req/ack to every inbound channel
// and keeps a per-test, per-channel scoreboard

`timescale 1ns/1ps
`default_nettype none

module link_calib_ctrl import link_pkg::*; (
  input  wire                      io_master_clk_i,
  input  wire                      reset_i,
  input  wire  [LINK_CHANNELS-1:0] test_ack_i,
  input  wire  [LINK_CHANNELS-1:0] test_pass_i,
  output calib_test_t              calib_test_o,
  output logic                     calib_done_o,
  output logic                     slave_reset_o,
  output logic [LINK_CHANNELS-1:0] chan_active_o
);

  calib_state_e                               state_r;
  logic [CAL_CNT_W-1:0]                       cnt_r;
  logic [TEST_IDX_W-1:0]                      index_r;
  // organized by test, then by channel
  logic [TEST_COUNT-1:0][LINK_CHANNELS-1:0]   score_r;
  logic [LINK_CHANNELS-1:0]                   all_pass;
  logic [LINK_CHANNELS-1:0]                   active_r;
  logic                                       round_end;
  logic                                       acks_low;

  // ------------------------------------------------------------
  // outputs decoded from state
  // ------------------------------------------------------------
  assign calib_test_o.req   = (state_r == CAL_TEST_REQ);
  assign calib_test_o.index = index_r;
  assign calib_done_o       = (state_r == CAL_DONE);
  // remote reset only during prepare
  assign slave_reset_o      = (state_r == CAL_PREPARE);
  assign chan_active_o      = active_r;

  // round ends when everyone answered or time ran out
  assign round_end = (&test_ack_i) || (cnt_r == CAL_CNT_W'(TEST_TIMEOUT - 1));
  assign acks_low  = ~(|test_ack_i);

  // a channel is usable only if it passed every test
  always_comb begin
    for (int c = 0; c < LINK_CHANNELS; c++) begin
      all_pass[c] = 1'b1;
      for (int k = 0; k < TEST_COUNT; k++) begin
        all_pass[c] = all_pass[c] & score_r[k][c];
      end
    end
  end

  // ------------------------------------------------------------
  // sequencer fsm
  // ------------------------------------------------------------
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      state_r  <= CAL_WAIT;
      cnt_r    <= '0;
      index_r  <= '0;
      score_r  <= '0;
      active_r <= '0;
    end else begin
      case (state_r)
        CAL_WAIT: begin
          // idle period after reset release
          if (cnt_r == CAL_CNT_W'(WAIT_AFTER_RESET - 1)) begin
            state_r <= CAL_PREPARE;
            cnt_r   <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        CAL_PREPARE: begin
          if (cnt_r == CAL_CNT_W'(PREPARE_CYCLES - 1)) begin
            state_r <= CAL_TEST_REQ;
            cnt_r   <= '0;
            index_r <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        CAL_TEST_REQ: begin
          // silent channels are scored as failed
          if (round_end) begin
            score_r[index_r] <= test_ack_i & test_pass_i;
            state_r          <= CAL_TEST_RELEASE;
            cnt_r            <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        CAL_TEST_RELEASE: begin
          // give timed out channels one cycle to pulse their late ack
          cnt_r <= cnt_r + 1'b1;
          if ((cnt_r != '0) && acks_low) begin
            cnt_r <= '0;
            if (index_r == TEST_IDX_W'(TEST_COUNT - 1)) begin
              state_r  <= CAL_DONE;
              active_r <= all_pass;
            end else begin
              state_r <= CAL_TEST_REQ;
              index_r <= index_r + 1'b1;
            end
          end
        end
        CAL_DONE: begin
          // calibration finished, active mask frozen
          state_r <= CAL_DONE;
        end
        default: begin
          state_r <= CAL_WAIT;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/link_channel_out.sv ====
// link outbound channel
// sends the calibration pattern until calibration is done, then moves
// core words onto the line under credit flow control; credits come back
// as edges of the token level

`timescale 1ns/1ps
`default_nettype none

module link_channel_out import link_pkg::*; (
  input  wire                      io_master_clk_i,
  input  wire                      reset_i,
  input  wire                      core_valid_i,
  input  wire  [CHANNEL_WIDTH-1:0] core_data_i,
  output logic                     core_ready_o,
  input  wire                      calib_done_i,
  input  wire                      chan_active_i,
  input  wire  [TEST_IDX_W-1:0]    test_index_i,
  input  wire                      token_i,
  output link_word_t               tline_o
);

  logic [CREDIT_W-1:0]      credit_r;
  logic [CREDIT_W-1:0]      credit_add;
  logic [CREDIT_W-1:0]      credit_sub;
  logic                     token_r;
  logic                     token_edge;
  logic                     send;
  logic                     valid_n;
  logic [CHANNEL_WIDTH-1:0] data_n;
  logic                     valid_r;
  logic [CHANNEL_WIDTH-1:0] data_r;

  // ------------------------------------------------------------
  // core handshake
  // ------------------------------------------------------------
  // ready only on an active, calibrated channel with credit left
  assign core_ready_o = chan_active_i & calib_done_i & (credit_r != '0);
  assign send         = core_valid_i & core_ready_o;

  // ------------------------------------------------------------
  // line word select
  // ------------------------------------------------------------
  always_comb begin
    if (calib_done_i) begin
      valid_n = send;
      data_n  = core_data_i;
    end else begin
      // calibration override, pattern of the current test
      valid_n = 1'b1;
      data_n  = TEST_PATTERN[test_index_i];
    end
  end

  // line register, word shows up one cycle after acceptance
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= valid_n;
    end
  end

  always_ff @(posedge io_master_clk_i) begin
    data_r <= data_n;
  end

  assign tline_o.valid = valid_r;
  assign tline_o.data  = data_r;

  // ------------------------------------------------------------
  // token edge detect and credit counter
  // ------------------------------------------------------------
  // token is a level, any change returns a batch of credits
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      token_r <= 1'b0;
    end else begin
      token_r <= token_i;
    end
  end

  assign token_edge = token_i ^ token_r;
  assign credit_add = token_edge ? CREDIT_W'(TOKEN_CREDITS) : '0;
  assign credit_sub = CREDIT_W'(send);

  // starts full, remote fifo is empty after reset
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      credit_r <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      credit_r <= credit_r - credit_sub + credit_add;
    end
  end

endmodule

`default_nettype wire

// ==== source/link_channel_in.sv ====
// link inbound channel
// during calibration, checks the received pattern and answers the
// sequencer's test request; afterwards, buffers line words in a fifo
// for the core and toggles the token every few dequeues

`timescale 1ns/1ps
`default_nettype none

module link_channel_in import link_pkg::*; (
  input  wire                      io_master_clk_i,
  input  wire                      reset_i,
  input  wire link_word_t          tline_i,
  input  wire calib_test_t         calib_test_i,
  input  wire                      calib_done_i,
  output logic                     test_ack_o,
  output logic                     test_pass_o,
  output logic                     core_valid_o,
  output logic [CHANNEL_WIDTH-1:0] core_data_o,
  input  wire                      core_yumi_i,
  output logic                     token_o
);

  logic                           calib_done_r;
  logic                           fifo_reset;
  logic [CHANNEL_WIDTH-1:0]       mem_r [FIFO_DEPTH];
  logic [LG_FIFO_DEPTH:0]         wptr_r;
  logic [LG_FIFO_DEPTH:0]         rptr_r;
  logic                           full;
  logic                           enq;
  logic                           deq;
  logic [LG_TOKEN_DECIMATION-1:0] deq_cnt_r;
  logic                           token_r;
  logic [CHANNEL_WIDTH-1:0]       expect_data;
  logic                           match;
  logic [HOLD_CNT_W-1:0]          hold_cnt_r;
  logic                           req_r;
  logic                           ack_r;
  logic                           pass_r;

  // ------------------------------------------------------------
  // calibration checker
  // ------------------------------------------------------------
  assign expect_data = TEST_PATTERN[calib_test_i.index];
  assign match = calib_test_i.req & tline_i.valid & (tline_i.data == expect_data);

  // run of consecutive matching words that saturates at the hold count
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i || !match) begin
      hold_cnt_r <= '0;
    end else if (hold_cnt_r != HOLD_CNT_W'(TEST_HOLD_CYCLES)) begin
      hold_cnt_r <= hold_cnt_r + 1'b1;
    end
  end

  // four-phase answer to the sequencer
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      req_r  <= 1'b0;
      ack_r  <= 1'b0;
      pass_r <= 1'b0;
    end else begin
      req_r <= calib_test_i.req;
      if (calib_test_i.req) begin
        // pass once the pattern held long enough
        if (!ack_r && hold_cnt_r == HOLD_CNT_W'(TEST_HOLD_CYCLES)) begin
          ack_r  <= 1'b1;
          pass_r <= 1'b1;
        end
      end else if (ack_r) begin
        ack_r  <= 1'b0;
        pass_r <= 1'b0;
      end else if (req_r) begin
        // round ended on timeout so ack late with fail
        ack_r  <= 1'b1;
        pass_r <= 1'b0;
      end
    end
  end

  assign test_ack_o  = ack_r;
  assign test_pass_o = pass_r;

  // ------------------------------------------------------------
  // receive fifo
  // ------------------------------------------------------------
  // the line still carries the last pattern word on the first done cycle
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      calib_done_r <= 1'b0;
    end else begin
      calib_done_r <= calib_done_i;
    end
  end

  // kept clear until the cycle after calibration ends so no pattern gets in
  assign fifo_reset = reset_i | ~calib_done_r;

  assign full = (wptr_r[LG_FIFO_DEPTH] != rptr_r[LG_FIFO_DEPTH]) &&
                (wptr_r[LG_FIFO_DEPTH-1:0] == rptr_r[LG_FIFO_DEPTH-1:0]);
  assign enq  = tline_i.valid & ~full;

  assign core_valid_o = (wptr_r != rptr_r);
  assign core_data_o  = mem_r[rptr_r[LG_FIFO_DEPTH-1:0]];
  assign deq          = core_yumi_i & core_valid_o;

  always_ff @(posedge io_master_clk_i) begin
    if (enq) begin
      mem_r[wptr_r[LG_FIFO_DEPTH-1:0]] <= tline_i.data;
    end
  end

  always_ff @(posedge io_master_clk_i) begin
    if (fifo_reset) begin
      wptr_r <= '0;
      rptr_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (deq) begin
        rptr_r <= rptr_r + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // token return
  // ------------------------------------------------------------
  // one toggle per 2**LG_TOKEN_DECIMATION dequeues
  always_ff @(posedge io_master_clk_i) begin
    if (fifo_reset) begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end else if (deq) begin
      deq_cnt_r <= deq_cnt_r + 1'b1;
      if (&deq_cnt_r) begin
        token_r <= ~token_r;
      end
    end
  end

  assign token_o = token_r;

endmodule

`default_nettype wire

// ==== source/link_kernel.sv ====
// link kernel, master side
// one calibration sequencer steering a pair of outbound and inbound
// channels per link channel, all on the io master clock

`timescale 1ns/1ps
`default_nettype none

module link_kernel import link_pkg::*; (
  input  wire                                          io_master_clk_i,
  input  wire                                          reset_i,
  // core in
  input  wire  [LINK_CHANNELS-1:0]                     core_valid_i,
  input  wire  [LINK_CHANNELS-1:0][CHANNEL_WIDTH-1:0]  core_data_i,
  output logic [LINK_CHANNELS-1:0]                     core_ready_o,
  // core out
  output logic [LINK_CHANNELS-1:0]                     core_valid_o,
  output logic [LINK_CHANNELS-1:0][CHANNEL_WIDTH-1:0]  core_data_o,
  input  wire  [LINK_CHANNELS-1:0]                     core_yumi_i,
  // transmission lines
  output link_tline_t                                  im_tline_o,
  input  wire link_tline_t                             io_tline_i,
  // tokens
  input  wire  [LINK_CHANNELS-1:0]                     token_i,
  output logic [LINK_CHANNELS-1:0]                     io_token_o,
  // link control
  output logic                                         im_slave_reset_o,
  output logic                                         core_calib_done_o,
  output logic [LINK_CHANNELS-1:0]                     core_active_channels_o
);

  calib_test_t              calib_test;
  logic                     calib_done;
  logic [LINK_CHANNELS-1:0] chan_active;
  logic [LINK_CHANNELS-1:0] test_ack;
  logic [LINK_CHANNELS-1:0] test_pass;

  // ------------------------------------------------------------
  // calibration sequencer
  // ------------------------------------------------------------
  link_calib_ctrl u_calib (
    .io_master_clk_i (io_master_clk_i),
    .reset_i         (reset_i),
    .test_ack_i      (test_ack),
    .test_pass_i     (test_pass),
    .calib_test_o    (calib_test),
    .calib_done_o    (calib_done),
    .slave_reset_o   (im_slave_reset_o),
    .chan_active_o   (chan_active)
  );

  assign core_calib_done_o      = calib_done;
  assign core_active_channels_o = chan_active;

  // ------------------------------------------------------------
  // per channel datapath
  // ------------------------------------------------------------
  for (genvar i = 0; i < LINK_CHANNELS; i++) begin : ch

    // outbound, pattern index follows the sequencer
    link_channel_out u_out (
      .io_master_clk_i (io_master_clk_i),
      .reset_i         (reset_i),
      .core_valid_i    (core_valid_i[i]),
      .core_data_i     (core_data_i[i]),
      .core_ready_o    (core_ready_o[i]),
      .calib_done_i    (calib_done),
      .chan_active_i   (chan_active[i]),
      .test_index_i    (calib_test.index),
      .token_i         (token_i[i]),
      .tline_o         (im_tline_o[i])
    );

    // inbound, answers the test request then feeds the core
    link_channel_in u_in (
      .io_master_clk_i (io_master_clk_i),
      .reset_i         (reset_i),
      .tline_i         (io_tline_i[i]),
      .calib_test_i    (calib_test),
      .calib_done_i    (calib_done),
      .test_ack_o      (test_ack[i]),
      .test_pass_o     (test_pass[i]),
      .core_valid_o    (core_valid_o[i]),
      .core_data_o     (core_data_o[i]),
      .core_yumi_i     (core_yumi_i[i]),
      .token_o         (io_token_o[i])
    );

  end

endmodule

`default_nettype wire

// ==== sim/link_kernel_chk.sv ====
// link kernel protocol checker
// bound to the kernel top level, watches the remote reset, the
// calibration done level, core ready and the active channel mask

`timescale 1ns/1ps
`default_nettype none

module link_kernel_chk import link_pkg::*; (
  input wire                     io_master_clk_i,
  input wire                     reset_i,
  input wire                     slave_reset_i,
  input wire                     calib_done_i,
  input wire [LINK_CHANNELS-1:0] ready_i,
  input wire [LINK_CHANNELS-1:0] active_i
);

  // remote reset belongs to the prepare phase only
  slave_reset_vs_done: assert property (@(posedge io_master_clk_i) disable iff (reset_i)
    !(slave_reset_i && calib_done_i))
    else $error("remote reset and calibration done high together");

  // no core words accepted before calibration ends
  ready_before_done: assert property (@(posedge io_master_clk_i) disable iff (reset_i)
    !calib_done_i |-> (ready_i == '0))
    else $error("core ready high before calibration done");

  // active mask frozen once calibration is done
  active_mask_stable: assert property (@(posedge io_master_clk_i) disable iff (reset_i)
    (calib_done_i && $past(calib_done_i)) |-> $stable(active_i))
    else $error("active channel mask changed after calibration");

endmodule

bind link_kernel link_kernel_chk u_chk (
  .io_master_clk_i (io_master_clk_i),
  .reset_i         (reset_i),
  .slave_reset_i   (im_slave_reset_o),
  .calib_done_i    (core_calib_done_o),
  .ready_i         (core_ready_o),
  .active_i        (core_active_channels_o)
);

`default_nettype wire

// ==== sim/link_kernel_tb.sv ====
// link kernel testbench
// loops the lines and tokens back onto the kernel, injects channel faults
// from the vector file, and checks reset values, calibration timing,
// active masks and core data flow

`timescale 1ns/1ps
`default_nettype none

module link_kernel_tb import link_pkg::*; ();

  localparam int CLK_HALF      = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int NUM_WORDS     = 16;
  localparam int VEC_LEN       = NUM_WORDS + 2;
  localparam int FAULT_CHANNEL = 1;
  localparam int BLOCK_CYCLES  = 30;
  localparam int REFUSE_CYCLES = 20;
  localparam int PHASE_LIMIT   = 100;
  localparam int CALIB_LIMIT   = 1000;
  localparam int TRAFFIC_LIMIT = 2000;
  localparam logic [15:0] LFSR_SEED = 16'd10168;
  localparam logic [LINK_CHANNELS-1:0] ALL_CHANNELS = '1;

  // dut ports, names match the kernel
  logic                                         io_master_clk_i = 1'b0;
  logic                                         reset_i;
  logic [LINK_CHANNELS-1:0]                     core_valid_i;
  logic [LINK_CHANNELS-1:0][CHANNEL_WIDTH-1:0]  core_data_i;
  logic [LINK_CHANNELS-1:0]                     core_ready_o;
  logic [LINK_CHANNELS-1:0]                     core_valid_o;
  logic [LINK_CHANNELS-1:0][CHANNEL_WIDTH-1:0]  core_data_o;
  logic [LINK_CHANNELS-1:0]                     core_yumi_i;
  link_tline_t                                  im_tline_o;
  link_tline_t                                  io_tline_i;
  logic [LINK_CHANNELS-1:0]                     token_i;
  logic [LINK_CHANNELS-1:0]                     io_token_o;
  logic                                         im_slave_reset_o;
  logic                                         core_calib_done_o;
  logic [LINK_CHANNELS-1:0]                     core_active_channels_o;

  // masked channels lose their data on the way back
  logic [LINK_CHANNELS-1:0] fault_mask;
  // fault mask, expected active mask, then data words
  logic [15:0]              vectors [VEC_LEN];
  logic [15:0]              lfsr_state;
  int                       errors;
  int                       tests_run;
  int                       tests_failed;
  int                       test_errors_start;
  int                       low_cycles;
  int                       high_cycles;

  // 8 ns clock
  always #CLK_HALF io_master_clk_i = ~io_master_clk_i;

  link_kernel DUT (.*);

  // ------------------------------------------------------------
  // external loopback with fault injection
  // ------------------------------------------------------------
  always_comb begin
    for (int c = 0; c < LINK_CHANNELS; c++) begin
      io_tline_i[c].valid = im_tline_o[c].valid;
      io_tline_i[c].data  = fault_mask[c] ? '0 : im_tline_o[c].data;
    end
  end

  // tokens go straight back
  assign token_i = io_token_o;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  // channel 1 in the upper byte, channel 0 in the lower
  function automatic logic [CHANNEL_WIDTH-1:0] word_for(input int chan, input int idx);
    logic [15:0] entry;
    entry = vectors[idx + 2];
    return entry[chan*CHANNEL_WIDTH +: CHANNEL_WIDTH];
  endfunction

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    $display("MISMATCH time %0d ns %s expected 0x%0h got 0x%0h", $time, sig, exp_v, got_v);
    errors++;
  endtask

  task automatic abort_run(input string what);
    $display("TIMEOUT time %0d ns %s", $time, what);
    $display("summary %0d tests run, %0d failed, %0d errors", tests_run + 1,
             tests_failed + 1, errors + 1);
    $display("Test failed");
    $finish;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %0d %s ... ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s ... FAILED with %0d errors", tests_run, name,
               errors - test_errors_start);
    end
    test_errors_start = errors;
  endtask

  // every control output from the reset list must be low
  task automatic check_idle_outputs();
    logic [LINK_CHANNELS-1:0] line_valid;
    for (int c = 0; c < LINK_CHANNELS; c++) begin
      line_valid[c] = im_tline_o[c].valid;
    end
    if (core_calib_done_o !== 1'b0) report_mismatch("core_calib_done_o", 0, 32'(core_calib_done_o));
    if (core_active_channels_o !== '0) begin
      report_mismatch("core_active_channels_o", 0, 32'(core_active_channels_o));
    end
    if (core_ready_o !== '0) report_mismatch("core_ready_o", 0, 32'(core_ready_o));
    if (core_valid_o !== '0) report_mismatch("core_valid_o", 0, 32'(core_valid_o));
    if (line_valid !== '0) report_mismatch("im_tline_o valid", 0, 32'(line_valid));
    if (im_slave_reset_o !== 1'b0) report_mismatch("im_slave_reset_o", 0, 32'(im_slave_reset_o));
    if (io_token_o !== '0) report_mismatch("io_token_o", 0, 32'(io_token_o));
  endtask

  // reset high for RESET_CYCLES rising edges, checked before release
  task automatic apply_reset();
    @(posedge io_master_clk_i);
    reset_i      <= 1'b1;
    core_valid_i <= '0;
    core_yumi_i  <= '0;
    repeat (RESET_CYCLES - 1) @(posedge io_master_clk_i);
    @(negedge io_master_clk_i);
    check_idle_outputs();
    @(posedge io_master_clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic wait_calib_done();
    int cycles;
    cycles = 0;
    while (core_calib_done_o !== 1'b1) begin
      if (cycles == CALIB_LIMIT) abort_run("calibration never finished");
      cycles++;
      @(negedge io_master_clk_i);
    end
  endtask

  // ------------------------------------------------------------
  // core traffic on all channels
  // ------------------------------------------------------------
  // yumi held low for block_cycles first, then random or always on
  task automatic run_traffic(input logic random_yumi, input int block_cycles);
    int                       sent [LINK_CHANNELS];
    int                       rcvd [LINK_CHANNELS];
    logic [LINK_CHANNELS-1:0] yumi_next;
    logic                     deq;
    logic                     rnd;
    logic                     all_done;
    int                       cycle;
    for (int c = 0; c < LINK_CHANNELS; c++) begin
      sent[c] = 0;
      rcvd[c] = 0;
    end
    yumi_next = '0;
    all_done  = 1'b0;
    cycle     = 0;
    while (!all_done) begin
      if (cycle == TRAFFIC_LIMIT) abort_run("core data transfer stalled");
      // new stimulus on the rising edge
      @(posedge io_master_clk_i);
      for (int c = 0; c < LINK_CHANNELS; c++) begin
        core_valid_i[c] <= (sent[c] < NUM_WORDS);
        core_data_i[c]  <= (sent[c] < NUM_WORDS) ? word_for(c, sent[c]) : '0;
        core_yumi_i[c]  <= yumi_next[c];
      end
      // handshakes sampled half a cycle later
      @(negedge io_master_clk_i);
      cycle++;
      all_done = 1'b1;
      for (int c = 0; c < LINK_CHANNELS; c++) begin
        if (core_valid_i[c] && core_ready_o[c]) sent[c]++;
        deq = core_yumi_i[c] && core_valid_o[c];
        if (deq) begin
          if (core_data_o[c] !== word_for(c, rcvd[c])) begin
            report_mismatch($sformatf("core_data_o[%0d]", c), 32'(word_for(c, rcvd[c])),
                            32'(core_data_o[c]));
          end
          rcvd[c]++;
        end
        // yumi only where valid surely holds next cycle
        yumi_next[c] = 1'b0;
        if (cycle >= block_cycles && core_valid_o[c] && !deq) begin
          if (random_yumi) begin
            random_bit(rnd);
            yumi_next[c] = rnd;
          end else begin
            yumi_next[c] = 1'b1;
          end
        end
        if (rcvd[c] < NUM_WORDS) all_done = 1'b0;
      end
      // end of stall, each sender full and stopped
      if (block_cycles > 0 && cycle == block_cycles) begin
        for (int c = 0; c < LINK_CHANNELS; c++) begin
          if (sent[c] != FIFO_DEPTH) begin
            report_mismatch($sformatf("accepted words ch%0d", c), FIFO_DEPTH, sent[c]);
          end
          if (core_ready_o[c] !== 1'b0) begin
            report_mismatch($sformatf("core_ready_o[%0d]", c), 0, 32'(core_ready_o[c]));
          end
        end
      end
    end
    @(posedge io_master_clk_i);
    core_valid_i <= '0;
    core_yumi_i  <= '0;
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    reset_i           = 1'b1;
    core_valid_i      = '0;
    core_data_i       = '0;
    core_yumi_i       = '0;
    fault_mask        = '0;
    lfsr_state        = LFSR_SEED;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_errors_start = 0;
    $readmemh("sim/link_vectors.txt", vectors);

    // reset values, during and right after reset
    apply_reset();
    @(negedge io_master_clk_i);
    check_idle_outputs();
    finish_test("control outputs low in and after reset");

    // wait and prepare lengths, counted on falling edges
    low_cycles = 0;
    while (im_slave_reset_o !== 1'b1) begin
      if (low_cycles == PHASE_LIMIT) abort_run("remote reset never rose");
      low_cycles++;
      @(negedge io_master_clk_i);
    end
    high_cycles = 0;
    while (im_slave_reset_o === 1'b1) begin
      if (high_cycles == PHASE_LIMIT) abort_run("remote reset never fell");
      high_cycles++;
      @(negedge io_master_clk_i);
    end
    if (low_cycles != WAIT_AFTER_RESET) begin
      report_mismatch("cycles before im_slave_reset_o", WAIT_AFTER_RESET, low_cycles);
    end
    if (high_cycles != PREPARE_CYCLES) begin
      report_mismatch("im_slave_reset_o high cycles", PREPARE_CYCLES, high_cycles);
    end
    wait_calib_done();
    finish_test("calibration timing");

    // clean loopback, every channel usable
    if (core_active_channels_o !== ALL_CHANNELS) begin
      report_mismatch("core_active_channels_o", 32'(ALL_CHANNELS), 32'(core_active_channels_o));
    end
    finish_test("all channels active without faults");

    run_traffic(1'b1, 0);
    finish_test("data order under random yumi stalls");

    run_traffic(1'b0, BLOCK_CYCLES);
    finish_test("back-pressure with yumi held low");

    // fresh calibration with the file's fault mask
    @(posedge io_master_clk_i);
    fault_mask <= vectors[0][LINK_CHANNELS-1:0];
    apply_reset();
    wait_calib_done();
    if (core_active_channels_o !== vectors[1][LINK_CHANNELS-1:0]) begin
      report_mismatch("core_active_channels_o", 32'(vectors[1][LINK_CHANNELS-1:0]),
                      32'(core_active_channels_o));
    end
    // faulty channel refuses core words
    @(posedge io_master_clk_i);
    core_valid_i[FAULT_CHANNEL] <= 1'b1;
    core_data_i[FAULT_CHANNEL]  <= word_for(FAULT_CHANNEL, 0);
    repeat (REFUSE_CYCLES) begin
      @(negedge io_master_clk_i);
      if (core_ready_o[FAULT_CHANNEL] !== 1'b0) begin
        report_mismatch("core_ready_o[1]", 0, 32'(core_ready_o[FAULT_CHANNEL]));
      end
    end
    @(posedge io_master_clk_i);
    core_valid_i <= '0;
    finish_test("fault mask from vector file");

    $display("summary %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/link_vectors.txt ====
// first line is the fault mask with one bit per channel, second line the expected active mask
// remaining lines are data words with channel 1 in the upper byte and channel 0 in the lower
0002
0001
a501
5a12
c323
3c34
0f45
f056
1e67
e178
2d89
d29a
4bab
b4bc
69cd
96de
87ef
78f0

// ==== files.f ====
source/link_pkg.sv
source/link_calib_ctrl.sv
source/link_channel_out.sv
source/link_channel_in.sv
source/link_kernel.sv
sim/link_kernel_chk.sv
sim/link_kernel_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the link kernel testbench with verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module link_kernel_tb -f files.f &&
  ./obj_dir/Vlink_kernel_tb | tee /dev/stderr | grep -q "^Test passed$" &&
  echo "simulation run ok" ||
  { echo "simulation run failed"; exit 1; }
